// File: hw/qracc_settings.svh
`ifndef QRACC_SETTINGS_SVH
`define QRACC_SETTINGS_SVH

// Array geometry
`define QRACC_ROWS 16
`define QRACC_COLS 8
`define QRACC_ROW_ADDR_BITS 4

// Input elements and their bit-planes
`define QRACC_INPUT_BITS 5
`define QRACC_TRITS (`QRACC_INPUT_BITS - 1)

// ADC and accumulation
`define QRACC_ADC_BITS 4
`define QRACC_ADC_SHIFT_BITS 2
// One extra bit covers growth from the shift-add
`define QRACC_ACC_BITS ((`QRACC_TRITS - 1) + `QRACC_ADC_BITS + 1)

// Output scaling by the ADC reference range
`define NUM_ADC_REF_RANGE_SHIFTS 1
`define QRACC_OUT_BITS (`QRACC_ACC_BITS + `NUM_ADC_REF_RANGE_SHIFTS)

// Wishbone port, word addressed
`define QRACC_WB_ADR_BITS 5
`define QRACC_WB_DAT_BITS 32
// Rows sit at 0..15, config right above them
`define QRACC_CFG_ADDR 16

`endif

// File: hw/qracc_pkg.sv
`include "qracc_settings.svh"

package qracc_pkg;

    // Datapath element types
    typedef logic signed [`QRACC_INPUT_BITS-1:0] in_elem_t;
    typedef logic [`QRACC_TRITS-1:0] plane_t;
    typedef logic signed [`QRACC_ADC_BITS-1:0] adc_t;
    typedef logic signed [`QRACC_ACC_BITS-1:0] acc_t;
    typedef logic signed [`QRACC_OUT_BITS-1:0] mac_out_t;

    // Weight bit 1 is +1, bit 0 is -1
    typedef logic [`QRACC_COLS-1:0] weight_row_t;
    typedef logic [`QRACC_ROW_ADDR_BITS-1:0] row_addr_t;

    // Array configuration
    typedef struct packed {
        // Arithmetic right shift of column sums before saturation
        logic [`QRACC_ADC_SHIFT_BITS-1:0] adc_shift;
    } qracc_config_t;

    // Register port toward the weight SRAM
    typedef struct packed {
        logic        wen;
        row_addr_t   addr;
        weight_row_t wdata;
    } to_sram_t;

    // Weight SRAM back to the register port
    typedef struct packed {
        weight_row_t rdata;
    } from_sram_t;

    // Wishbone slave FSM
    typedef enum logic {
        IDLE,
        ACK
    } qracc_state_e;

endpackage

// File: hw/twos_to_bipolar.sv
`timescale 1ns/1ps
`include "qracc_settings.svh"

module twos_to_bipolar
    import qracc_pkg::*;
#(
    parameter int NUM_LANES = `QRACC_ROWS
) (
    input  in_elem_t twos_i      [NUM_LANES],
    output plane_t   bipolar_p_o [NUM_LANES],
    output plane_t   bipolar_n_o [NUM_LANES]
);

    localparam int IN_BITS = $bits(in_elem_t);
    localparam int PLANE_BITS = $bits(plane_t);
    // Largest magnitude one plane word holds
    localparam plane_t MAG_MAX = '1;

    always_comb begin
        in_elem_t neg;
        for (int i = 0; i < NUM_LANES; i++) begin
            neg = -twos_i[i];
            if (!twos_i[i][IN_BITS-1]) begin
                // Non-negative goes straight to the positive plane
                bipolar_p_o[i] = twos_i[i][PLANE_BITS-1:0];
                bipolar_n_o[i] = '0;
            end else begin
                bipolar_p_o[i] = '0;
                // Most negative value negates to itself, clamp it
                if (neg[IN_BITS-1]) begin
                    bipolar_n_o[i] = MAG_MAX;
                end else begin
                    bipolar_n_o[i] = neg[PLANE_BITS-1:0];
                end
            end
        end
    end

endmodule

// File: hw/qr_acc_array.sv
`timescale 1ns/1ps
`include "qracc_settings.svh"

module qr_acc_array
    import qracc_pkg::*;
(
    input  logic                    clk,
    input  logic                    nrst,
    input  qracc_config_t           cfg_i,
    input  logic                    mac_en_i,
    input  logic [`QRACC_ROWS-1:0]  data_p_i,
    input  logic [`QRACC_ROWS-1:0]  data_n_i,
    output adc_t                    adc_out_o [`QRACC_COLS],
    input  to_sram_t                to_sram_i,
    output from_sram_t              from_sram_o
);

    localparam int ROWS = `QRACC_ROWS;
    localparam int COLS = `QRACC_COLS;
    // Column sum spans -ROWS..ROWS
    localparam int SUM_BITS = $clog2(ROWS) + 2;
    localparam int ADC_BITS = $bits(adc_t);
    localparam int CODE_LIMIT = 2 ** (ADC_BITS - 1);
    localparam logic signed [SUM_BITS-1:0] CODE_MAX = SUM_BITS'(CODE_LIMIT - 1);
    localparam logic signed [SUM_BITS-1:0] CODE_MIN = SUM_BITS'(-CODE_LIMIT);

    weight_row_t sram_q [ROWS];
    weight_row_t rdata_q;
    logic signed [SUM_BITS-1:0] col_sum [COLS];
    adc_t adc_d [COLS];

    // Weight SRAM, one row per input element
    always_ff @(posedge clk) begin
        if (to_sram_i.wen) begin
            sram_q[to_sram_i.addr] <= to_sram_i.wdata;
        end
        rdata_q <= sram_q[to_sram_i.addr];
    end

    assign from_sram_o = '{rdata: rdata_q};

    // Signed dot product of the current plane bits per column
    always_comb begin
        for (int c = 0; c < COLS; c++) begin
            col_sum[c] = '0;
            for (int r = 0; r < ROWS; r++) begin
                // Row drives +1 or -1 only when exactly one plane is set
                if (data_p_i[r] != data_n_i[r]) begin
                    if (sram_q[r][c] == data_p_i[r]) begin
                        col_sum[c] = col_sum[c] + SUM_BITS'(1);
                    end else begin
                        col_sum[c] = col_sum[c] - SUM_BITS'(1);
                    end
                end
            end
        end
    end

    // ADC model: range shift then clamp to the code range
    always_comb begin
        logic signed [SUM_BITS-1:0] shifted;
        for (int c = 0; c < COLS; c++) begin
            shifted = col_sum[c] >>> cfg_i.adc_shift;
            if (shifted > CODE_MAX) begin
                adc_d[c] = adc_t'(CODE_MAX);
            end else if (shifted < CODE_MIN) begin
                adc_d[c] = adc_t'(CODE_MIN);
            end else begin
                adc_d[c] = adc_t'(shifted);
            end
        end
    end

    // Codes are held between conversions
    always_ff @(posedge clk) begin
        if (!nrst) begin
            adc_out_o <= '{default: '0};
        end else if (mac_en_i) begin
            adc_out_o <= adc_d;
        end
    end

    // Converter and PISO never put one row on both planes
    a_planes_exclusive: assert property (
        @(posedge clk) disable iff (!nrst)
        mac_en_i |-> ((data_p_i & data_n_i) == '0)
    );

endmodule

// File: hw/seq_acc.sv
`timescale 1ns/1ps
`include "qracc_settings.svh"

module seq_acc
    import qracc_pkg::*;
(
    input  logic          clk,
    input  logic          nrst,
    input  qracc_config_t cfg_i,

    // Input vector stream
    input  in_elem_t      mac_data_i [`QRACC_ROWS],
    input  logic          mac_valid_i,
    output logic          ready_o,

    // Result pulse
    output logic          valid_o,
    output mac_out_t      mac_data_o [`QRACC_COLS],

    // Weight SRAM port
    input  to_sram_t      to_sram_i,
    output from_sram_t    from_sram_o
);

    localparam int ROWS = `QRACC_ROWS;
    localparam int COLS = `QRACC_COLS;
    localparam int TRITS = `QRACC_TRITS;
    // Planes, then one ADC stage and one accumulate stage
    localparam int STAGES = TRITS + 2;
    // ADC code enters the accumulator at its top bits
    localparam int ACC_ALIGN = `QRACC_ACC_BITS - `QRACC_ADC_BITS - 1;

    logic [STAGES-1:0] pipeline_tracker;
    plane_t piso_p_q [ROWS];
    plane_t piso_n_q [ROWS];
    plane_t piso_p_d [ROWS];
    plane_t piso_n_d [ROWS];
    logic [ROWS-1:0] data_p;
    logic [ROWS-1:0] data_n;
    adc_t adc_out [COLS];
    acc_t accumulator [COLS];
    logic mac_en;
    logic accept;

    twos_to_bipolar #(
        .NUM_LANES(ROWS)
    ) u_twos_to_bipolar (
        .twos_i     (mac_data_i),
        .bipolar_p_o(piso_p_d),
        .bipolar_n_o(piso_n_d)
    );

    qr_acc_array u_qr_acc_array (
        .clk        (clk),
        .nrst       (nrst),
        .cfg_i      (cfg_i),
        .mac_en_i   (mac_en),
        .data_p_i   (data_p),
        .data_n_i   (data_n),
        .adc_out_o  (adc_out),
        .to_sram_i  (to_sram_i),
        .from_sram_o(from_sram_o)
    );

    assign accept = mac_valid_i && ready_o;

    // PISO buffers, LSB plane first
    always_ff @(posedge clk) begin
        for (int r = 0; r < ROWS; r++) begin
            if (accept) begin
                piso_p_q[r] <= piso_p_d[r];
                piso_n_q[r] <= piso_n_d[r];
            end else begin
                piso_p_q[r] <= piso_p_q[r] >> 1;
                piso_n_q[r] <= piso_n_q[r] >> 1;
            end
        end
    end

    // One bit per vector marching through the stages
    always_ff @(posedge clk) begin
        if (!nrst) begin
            pipeline_tracker <= '0;
        end else begin
            pipeline_tracker <= {pipeline_tracker[STAGES-2:0], accept};
        end
    end

    // Shift-add, so plane k ends up weighted by 2^k
    always_ff @(posedge clk) begin
        if (!nrst) begin
            accumulator <= '{default: '0};
        end else begin
            for (int c = 0; c < COLS; c++) begin
                if (pipeline_tracker[1]) begin
                    accumulator[c] <= acc_t'(adc_out[c]) <<< ACC_ALIGN;
                end else begin
                    accumulator[c] <= (accumulator[c] >>> 1)
                                    + (acc_t'(adc_out[c]) <<< ACC_ALIGN);
                end
            end
        end
    end

    // Busy while a vector still has planes left to stream
    assign ready_o = (pipeline_tracker[TRITS-2:0] == '0);
    assign valid_o = pipeline_tracker[STAGES-1];
    assign mac_en = |pipeline_tracker[TRITS-1:0];

    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            data_p[r] = piso_p_q[r][0];
            data_n[r] = piso_n_q[r][0];
        end
        for (int c = 0; c < COLS; c++) begin
            mac_data_o[c] = mac_out_t'(accumulator[c]) <<< `NUM_ADC_REF_RANGE_SHIFTS;
        end
    end

    a_valid_single: assert property (
        @(posedge clk) disable iff (!nrst)
        valid_o |=> !valid_o
    );

    // Accepts are spaced by at least one full plane sequence
    a_accept_spacing: assert property (
        @(posedge clk) disable iff (!nrst)
        accept |=> (!accept) [*TRITS-1]
    );

endmodule

// File: hw/qracc_wb_regs.sv
`timescale 1ns/1ps
`include "qracc_settings.svh"

module qracc_wb_regs
    import qracc_pkg::*;
(
    input  logic                          clk,
    input  logic                          nrst,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  logic [`QRACC_WB_ADR_BITS-1:0] wb_adr_i,
    input  logic [`QRACC_WB_DAT_BITS-1:0] wb_dat_i,
    output logic [`QRACC_WB_DAT_BITS-1:0] wb_dat_o,
    output logic                          wb_ack_o,
    output qracc_config_t                 cfg_o,
    output to_sram_t                      to_sram_o,
    input  from_sram_t                    from_sram_i
);

    localparam int ADR_BITS = `QRACC_WB_ADR_BITS;
    localparam int DAT_BITS = `QRACC_WB_DAT_BITS;
    localparam int ROW_BITS = $bits(row_addr_t);
    localparam logic [ADR_BITS-1:0] CFG_ADDR = ADR_BITS'(`QRACC_CFG_ADDR);

    qracc_state_e state_q;
    qracc_state_e state_d;
    logic [ADR_BITS-1:0] adr_q;
    qracc_config_t cfg_q;
    logic req;
    logic row_sel;

    // New request only taken from IDLE
    assign req = wb_cyc_i && wb_stb_i && (state_q == IDLE);
    assign row_sel = (wb_adr_i[ADR_BITS-1:ROW_BITS] == '0);

    always_comb begin
        case (state_q)
            IDLE:    state_d = req ? ACK : IDLE;
            ACK:     state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state_q <= IDLE;
            cfg_q <= '0;
        end else begin
            state_q <= state_d;
            if (req && wb_we_i && (wb_adr_i == CFG_ADDR)) begin
                cfg_q.adc_shift <= wb_dat_i[$bits(cfg_q.adc_shift)-1:0];
            end
        end
    end

    // Address kept for the read mux in the ACK cycle
    always_ff @(posedge clk) begin
        if (req) begin
            adr_q <= wb_adr_i;
        end
    end

    // Array registers the addressed row on the same edge
    assign to_sram_o.wen = req && wb_we_i && row_sel;
    assign to_sram_o.addr = wb_adr_i[ROW_BITS-1:0];
    assign to_sram_o.wdata = wb_dat_i[$bits(weight_row_t)-1:0];

    assign wb_ack_o = (state_q == ACK);
    assign cfg_o = cfg_q;

    always_comb begin
        if (adr_q[ADR_BITS-1:ROW_BITS] == '0) begin
            wb_dat_o = DAT_BITS'(from_sram_i.rdata);
        end else if (adr_q == CFG_ADDR) begin
            wb_dat_o = DAT_BITS'(cfg_q);
        end else begin
            wb_dat_o = '0;
        end
    end

    a_ack_after_stb: assert property (
        @(posedge clk) disable iff (!nrst)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i)
    );

endmodule

// File: hw/qracc_top.sv
`timescale 1ns/1ps
`include "qracc_settings.svh"

module qracc_top
    import qracc_pkg::*;
(
    input  logic                          clk,
    input  logic                          nrst,

    // Wishbone classic slave for weights and config
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  logic [`QRACC_WB_ADR_BITS-1:0] wb_adr_i,
    input  logic [`QRACC_WB_DAT_BITS-1:0] wb_dat_i,
    output logic [`QRACC_WB_DAT_BITS-1:0] wb_dat_o,
    output logic                          wb_ack_o,

    // MAC stream
    input  in_elem_t                      mac_data_i [`QRACC_ROWS],
    input  logic                          mac_valid_i,
    output logic                          ready_o,
    output logic                          valid_o,
    output mac_out_t                      mac_data_o [`QRACC_COLS]
);

    qracc_config_t cfg;
    to_sram_t to_sram;
    from_sram_t from_sram;

    qracc_wb_regs u_qracc_wb_regs (
        .clk        (clk),
        .nrst       (nrst),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .cfg_o      (cfg),
        .to_sram_o  (to_sram),
        .from_sram_i(from_sram)
    );

    seq_acc u_seq_acc (
        .clk        (clk),
        .nrst       (nrst),
        .cfg_i      (cfg),
        .mac_data_i (mac_data_i),
        .mac_valid_i(mac_valid_i),
        .ready_o    (ready_o),
        .valid_o    (valid_o),
        .mac_data_o (mac_data_o),
        .to_sram_i  (to_sram),
        .from_sram_o(from_sram)
    );

endmodule

// File: verif/tb_qracc_top.sv
`timescale 1ns/1ps
`include "qracc_settings.svh"

module tb_qracc_top
    import qracc_pkg::*;
();

    localparam int ROWS = `QRACC_ROWS;
    localparam int COLS = `QRACC_COLS;
    localparam int IN_BITS = `QRACC_INPUT_BITS;
    localparam int TRITS = `QRACC_TRITS;
    localparam int VEC_BITS = ROWS * IN_BITS;
    localparam int CODE_MAX = 2 ** (`QRACC_ADC_BITS - 1) - 1;
    localparam int CODE_MIN = -(2 ** (`QRACC_ADC_BITS - 1));
    localparam int MAG_MAX = 2 ** TRITS - 1;
    localparam int WAIT_LIMIT = 100;

    logic clk;
    logic nrst;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [`QRACC_WB_ADR_BITS-1:0] wb_adr;
    logic [`QRACC_WB_DAT_BITS-1:0] wb_dat_w;
    logic [`QRACC_WB_DAT_BITS-1:0] wb_dat_r;
    logic wb_ack;
    in_elem_t mac_data [ROWS];
    logic mac_valid;
    logic ready;
    logic valid;
    mac_out_t mac_result [COLS];

    // Model state mirrored from Wishbone writes
    weight_row_t weights [ROWS];
    int adc_shift_ref;
    string test_name;

    // Vectors in flight, oldest first
    logic [VEC_BITS-1:0] pend_vec [$];
    int pend_shift [$];
    string pend_name [$];
    int pend_edge [$];

    int edge_count = 0;
    int errors = 0;
    int checks = 0;
    integer seed;

    qracc_top dut_i (
        .clk        (clk),
        .nrst       (nrst),
        .wb_cyc_i   (wb_cyc),
        .wb_stb_i   (wb_stb),
        .wb_we_i    (wb_we),
        .wb_adr_i   (wb_adr),
        .wb_dat_i   (wb_dat_w),
        .wb_dat_o   (wb_dat_r),
        .wb_ack_o   (wb_ack),
        .mac_data_i (mac_data),
        .mac_valid_i(mac_valid),
        .ready_o    (ready),
        .valid_o    (valid),
        .mac_data_o (mac_result)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    // Expected result of one column for one input vector
    function automatic int ref_column(input logic [VEC_BITS-1:0] vec, input int col,
                                      input int shift);
        int acc;
        int sum;
        int code;
        int x;
        int p;
        int n;
        int w;
        acc = 0;
        for (int k = 0; k < TRITS; k++) begin
            sum = 0;
            for (int r = 0; r < ROWS; r++) begin
                x = $signed(vec[r*IN_BITS +: IN_BITS]);
                p = (x >= 0) ? x : 0;
                n = (x >= 0) ? 0 : ((-x > MAG_MAX) ? MAG_MAX : -x);
                w = weights[r][col] ? 1 : -1;
                sum = sum + w * (((p >> k) & 1) - ((n >> k) & 1));
            end
            code = sum >>> shift;
            if (code > CODE_MAX) code = CODE_MAX;
            if (code < CODE_MIN) code = CODE_MIN;
            acc = acc + code * (2 ** k);
        end
        return acc * (2 ** `NUM_ADC_REF_RANGE_SHIFTS);
    endfunction

    // Sparse vectors keep at most seven rows active
    function automatic logic [VEC_BITS-1:0] random_vector(input int sparse_ofs);
        logic [VEC_BITS-1:0] v;
        int x;
        for (int r = 0; r < ROWS; r++) begin
            x = $random(seed);
            if (sparse_ofs >= 0) begin
                x = ((r + sparse_ofs) % ROWS < 7) ? x % 16 : 0;
            end
            v[r*IN_BITS +: IN_BITS] = x[IN_BITS-1:0];
        end
        return v;
    endfunction

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        errors++;
        finish_run();
    endtask

    // Classic cycle, held until ack
    task automatic wb_access(input logic we, input logic [4:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdat);
        int n;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = dat;
        n = 0;
        @(posedge clk);
        #1;
        while (!wb_ack && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!wb_ack) stop_on_timeout("Wishbone ack");
        rdat = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_write(input logic [4:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_access(1'b1, adr, dat, unused);
        if (adr < ROWS) weights[adr[3:0]] = dat[COLS-1:0];
        if (adr == `QRACC_CFG_ADDR) adc_shift_ref = dat[`QRACC_ADC_SHIFT_BITS-1:0];
    endtask

    task automatic wb_read(input logic [4:0] adr, output logic [31:0] dat);
        wb_access(1'b0, adr, 32'h0, dat);
    endtask

    // Leaves mac_valid high so the next call can follow back to back
    task automatic send_vector(input logic [VEC_BITS-1:0] vec, output int edges);
        for (int r = 0; r < ROWS; r++) begin
            mac_data[r] = vec[r*IN_BITS +: IN_BITS];
        end
        mac_valid = 1'b1;
        edges = 0;
        while (!ready && edges < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            edges++;
        end
        if (!ready) stop_on_timeout("ready_o");
        @(posedge clk);
        #1;
        edges++;
    endtask

    task automatic drain();
        int n;
        mac_valid = 1'b0;
        n = 0;
        while (pend_vec.size() != 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (pend_vec.size() != 0) stop_on_timeout("valid_o");
    endtask

    // Results checked first, then a pending accept is recorded
    always @(negedge clk) begin : check_results
        logic [VEC_BITS-1:0] vec;
        int shift;
        int exp;
        int act;
        int lat;
        string name;
        if (nrst && valid) begin
            if (pend_vec.size() == 0) begin
                $display("valid_o pulsed with no vector in flight");
                errors++;
            end else begin
                vec = pend_vec.pop_front();
                shift = pend_shift.pop_front();
                name = pend_name.pop_front();
                lat = edge_count - pend_edge.pop_front();
                checks++;
                if (lat != TRITS + 1) begin
                    $display("ERROR %s latency: expected %0d, actual %0d", name, TRITS + 1, lat);
                    errors++;
                end
                for (int c = 0; c < COLS; c++) begin
                    exp = ref_column(vec, c, shift);
                    act = mac_result[c];
                    checks++;
                    if (exp != act) begin
                        $display("ERROR %s col %0d: expected %0d, actual %0d", name, c, exp, act);
                        errors++;
                    end
                end
            end
        end
        if (nrst && mac_valid && ready) begin
            for (int r = 0; r < ROWS; r++) begin
                vec[r*IN_BITS +: IN_BITS] = mac_data[r];
            end
            pend_vec.push_back(vec);
            pend_shift.push_back(adc_shift_ref);
            pend_name.push_back(test_name);
            pend_edge.push_back(edge_count + 1);
        end
    end

    initial begin
        int edges;
        logic [31:0] rd;
        seed = 32'h90dd_caa0;
        nrst = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        mac_valid = 1'b0;
        mac_data = '{default: '0};
        adc_shift_ref = 0;
        test_name = "reset";
        repeat (2) @(posedge clk);
        #1;
        nrst = 1'b1;

        test_name = "wb_regs";
        for (int r = 0; r < ROWS; r++) wb_write(5'(r), $random(seed));
        for (int r = 0; r < ROWS; r++) begin
            wb_read(5'(r), rd);
            checks++;
            if (rd != {24'h0, weights[r]}) begin
                $display("ERROR %s row %0d: expected %h, actual %h", test_name, r,
                         {24'h0, weights[r]}, rd);
                errors++;
            end
        end
        wb_write(`QRACC_CFG_ADDR, 32'h3);
        wb_read(`QRACC_CFG_ADDR, rd);
        checks++;
        if (rd != 32'h3) begin
            $display("ERROR %s cfg: expected %h, actual %h", test_name, 32'h3, rd);
            errors++;
        end
        // Unmapped word ignores writes and reads back zero
        wb_write(5'd21, 32'hffff_ffff);
        wb_read(5'd21, rd);
        checks++;
        if (rd != 32'h0) begin
            $display("ERROR %s unmapped: expected %h, actual %h", test_name, 32'h0, rd);
            errors++;
        end
        // Neither the config nor the row sharing the low address bits changed
        wb_read(`QRACC_CFG_ADDR, rd);
        checks++;
        if (rd != 32'h3) begin
            $display("ERROR %s cfg after unmapped write: expected %h, actual %h", test_name,
                     32'h3, rd);
            errors++;
        end
        wb_read(5'd5, rd);
        checks++;
        if (rd != {24'h0, weights[5]}) begin
            $display("ERROR %s row 5 after unmapped write: expected %h, actual %h", test_name,
                     {24'h0, weights[5]}, rd);
            errors++;
        end
        wb_write(`QRACC_CFG_ADDR, 32'h0);

        test_name = "small_random";
        for (int i = 0; i < 8; i++) begin
            send_vector(random_vector(i), edges);
            drain();
        end

        // Same weight row everywhere puts every column sum at +-16
        test_name = "saturation";
        for (int r = 0; r < ROWS; r++) wb_write(5'(r), 32'h5a);
        send_vector({ROWS{5'sd15}}, edges);
        drain();
        send_vector({ROWS{-5'sd16}}, edges);
        drain();

        test_name = "adc_shift_2";
        for (int r = 0; r < ROWS; r++) wb_write(5'(r), $random(seed));
        wb_write(`QRACC_CFG_ADDR, 32'h2);
        for (int i = 0; i < 8; i++) begin
            send_vector(random_vector(-1), edges);
            drain();
        end

        test_name = "back_to_back";
        for (int i = 0; i < 6; i++) begin
            send_vector(random_vector(-1), edges);
            if (i > 0) begin
                checks++;
                if (edges != TRITS) begin
                    $display("ERROR %s accept spacing: expected %0d, actual %0d", test_name,
                             TRITS, edges);
                    errors++;
                end
            end
        end
        drain();

        finish_run();
    end

endmodule

// File: verilog.f
+incdir+hw
hw/qracc_pkg.sv
hw/twos_to_bipolar.sv
hw/qr_acc_array.sv
hw/seq_acc.sv
hw/qracc_wb_regs.sv
hw/qracc_top.sv
verif/tb_qracc_top.sv

// File: Bender.yml
package:
  name: qracc

sources:
  - include_dirs:
      - hw
    files:
      - hw/qracc_pkg.sv
      - hw/twos_to_bipolar.sv
      - hw/qr_acc_array.sv
      - hw/seq_acc.sv
      - hw/qracc_wb_regs.sv
      - hw/qracc_top.sv

  - target: test
    include_dirs:
      - hw
    files:
      - verif/tb_qracc_top.sv
